//--- hw/rnn_macros.svh
`ifndef RNN_MACROS_SVH
`define RNN_MACROS_SVH

// vector length and number of time steps
`define RNN_DIM 3
`define RNN_STEPS 3

// Q8.8 data word
`define RNN_DATA_W 16
`define RNN_FRAC 8

// room for three full 32-bit products plus growth
`define RNN_ACC_W 36

// hidden clamp ceiling, 1.0 in Q8.8
`define RNN_H_MAX 256

// serial words per load, one matrix element per cycle
`define RNN_LOAD_LEN 9

`endif

//--- hw/rnn_pkg.sv
`default_nettype none

`include "rnn_macros.svh"

package rnn_pkg;

	typedef logic signed [`RNN_DATA_W-1:0] data_t;
	typedef logic signed [`RNN_ACC_W-1:0] acc_t;
	typedef logic [1:0] step_t;
	typedef logic [1:0] row_t;
	typedef data_t [`RNN_DIM-1:0] vec_t;
	typedef vec_t [`RNN_DIM-1:0] mat_t;

	typedef enum logic {load_idle, load_busy} load_state_t;
	typedef enum logic {emit_wait, emit_rows} emit_state_t;

	localparam acc_t DATA_MAX = acc_t'(2 ** (`RNN_DATA_W - 1) - 1);
	localparam acc_t DATA_MIN = acc_t'(-(2 ** (`RNN_DATA_W - 1)));

	// three-term dot product, rescaled to Q8.8 and saturated
	function automatic data_t dot3(input vec_t a, input vec_t b);
		acc_t sum;
		acc_t scaled;
		sum = '0;
		for (int i = 0; i < `RNN_DIM; i++) begin
			sum = sum + acc_t'($signed(a[i])) * acc_t'($signed(b[i]));
		end
		scaled = sum >>> `RNN_FRAC;
		if (scaled > DATA_MAX)
			return data_t'(DATA_MAX);
		if (scaled < DATA_MIN)
			return data_t'(DATA_MIN);
		return data_t'(scaled);
	endfunction

endpackage

`default_nettype wire

//--- hw/proj_if.sv
`default_nettype none

// one projection row result per valid cycle, no stall
interface proj_if;

	logic           valid;
	rnn_pkg::step_t step;
	rnn_pkg::row_t  row;
	rnn_pkg::data_t value;

	modport src (output valid, output step, output row, output value);

	modport dst (input valid, input step, input row, input value);

endinterface

`default_nettype wire

//--- hw/weight_store.sv
`default_nettype none

`include "rnn_macros.svh"

module weight_store (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid,
	input  rnn_pkg::data_t weight_u,
	input  rnn_pkg::data_t weight_w,
	input  rnn_pkg::data_t weight_v,
	input  rnn_pkg::data_t data_x,
	output rnn_pkg::mat_t  u_mat,
	output rnn_pkg::mat_t  w_mat,
	output rnn_pkg::mat_t  v_mat,
	output rnn_pkg::mat_t  x_mat,
	output logic           start
);

	rnn_pkg::load_state_t state;
	logic [3:0]           cnt;
	logic [3:0]           slot;
	logic [3:0]           slot_row;
	logic [3:0]           slot_col;

	// first word lands while still idle, so its slot is 0
	assign slot     = (state == rnn_pkg::load_busy) ? cnt : 4'd0;
	assign slot_row = slot / 4'(`RNN_DIM);
	assign slot_col = slot % 4'(`RNN_DIM);

	//============================================================
	// load sequencing
	//============================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= rnn_pkg::load_idle;
			cnt   <= '0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				rnn_pkg::load_idle: begin
					if (in_valid) begin
						state <= rnn_pkg::load_busy;
						cnt   <= 4'd1;
					end
				end
				rnn_pkg::load_busy: begin
					if (in_valid) begin
						cnt <= cnt + 4'd1;
						// ninth word, hand off to the projections
						if (cnt == 4'(`RNN_LOAD_LEN - 1)) begin
							state <= rnn_pkg::load_idle;
							cnt   <= '0;
							start <= 1'b1;
						end
					end
				end
				default: state <= rnn_pkg::load_idle;
			endcase
		end
	end

	// row-major placement, x rows are the three time steps
	always_ff @(posedge clk) begin
		if (in_valid) begin
			u_mat[slot_row][slot_col] <= weight_u;
			w_mat[slot_row][slot_col] <= weight_w;
			v_mat[slot_row][slot_col] <= weight_v;
			x_mat[slot_row][slot_col] <= data_x;
		end
	end

	// words arrive back to back once a load has begun
	assert property (@(posedge clk) disable iff (!rst_n)
		(state == rnn_pkg::load_busy) |-> in_valid)
		else $error("weight_store: in_valid dropped before the ninth word");

endmodule

`default_nettype wire

//--- hw/input_projection.sv
`default_nettype none

`include "rnn_macros.svh"

module input_projection (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          start,
	input  rnn_pkg::mat_t u_mat,
	input  rnn_pkg::mat_t x_mat,
	proj_if.src           u_proj
);

	localparam rnn_pkg::step_t STEP_LAST = rnn_pkg::step_t'(`RNN_STEPS - 1);
	localparam rnn_pkg::row_t  ROW_LAST  = rnn_pkg::row_t'(`RNN_DIM - 1);

	logic           busy;
	rnn_pkg::step_t step_q;
	rnn_pkg::row_t  row_q;
	logic           fire;
	rnn_pkg::step_t cur_step;
	rnn_pkg::row_t  cur_row;

	// start produces step 0 row 0 straight away
	assign fire     = start | busy;
	assign cur_step = start ? '0 : step_q;
	assign cur_row  = start ? '0 : row_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy         <= 1'b0;
			step_q       <= '0;
			row_q        <= '0;
			u_proj.valid <= 1'b0;
		end else begin
			u_proj.valid <= fire;
			if (fire) begin
				if (cur_row == ROW_LAST) begin
					row_q  <= '0;
					step_q <= cur_step + 1'b1;
					busy   <= (cur_step != STEP_LAST);
				end else begin
					row_q  <= cur_row + 1'b1;
					step_q <= cur_step;
					busy   <= 1'b1;
				end
			end
		end
	end

	// U row times x of the current step
	always_ff @(posedge clk) begin
		if (fire) begin
			u_proj.step  <= cur_step;
			u_proj.row   <= cur_row;
			u_proj.value <= rnn_pkg::dot3(u_mat[cur_row], x_mat[cur_step]);
		end
	end

endmodule

`default_nettype wire

//--- hw/recurrent_projection.sv
`default_nettype none

`include "rnn_macros.svh"

module recurrent_projection (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          start,
	input  logic          h_valid,
	input  rnn_pkg::vec_t h_vec,
	input  rnn_pkg::mat_t w_mat,
	proj_if.src           w_proj
);

	localparam rnn_pkg::row_t ROW_LAST = rnn_pkg::row_t'(`RNN_DIM - 1);

	logic           busy;
	rnn_pkg::step_t step_q;
	rnn_pkg::row_t  row_q;
	rnn_pkg::vec_t  h_prev;
	logic           fire;
	rnn_pkg::step_t cur_step;
	rnn_pkg::row_t  cur_row;
	rnn_pkg::vec_t  h_use;

	assign fire    = start | h_valid | busy;
	assign cur_row = (start | h_valid) ? '0 : row_q;

	// h_0 is zero, later steps take the published hidden state
	always_comb begin
		if (start) begin
			cur_step = '0;
			h_use    = '0;
		end else if (h_valid) begin
			cur_step = step_q + 1'b1;
			h_use    = h_vec;
		end else begin
			cur_step = step_q;
			h_use    = h_prev;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy         <= 1'b0;
			step_q       <= '0;
			row_q        <= '0;
			w_proj.valid <= 1'b0;
		end else begin
			w_proj.valid <= fire;
			if (fire) begin
				step_q <= cur_step;
				row_q  <= cur_row + 1'b1;
				busy   <= (cur_row != ROW_LAST);
			end
		end
	end

	// keep h for rows 1 and 2 of the same step
	always_ff @(posedge clk) begin
		if (fire) begin
			h_prev       <= h_use;
			w_proj.step  <= cur_step;
			w_proj.row   <= cur_row;
			w_proj.value <= rnn_pkg::dot3(w_mat[cur_row], h_use);
		end
	end

endmodule

`default_nettype wire

//--- hw/cell_output.sv
`default_nettype none

`include "rnn_macros.svh"

module cell_output (
	input  logic           clk,
	input  logic           rst_n,
	input  rnn_pkg::mat_t  v_mat,
	proj_if.dst            u_proj,
	proj_if.dst            w_proj,
	output logic           h_valid,
	output rnn_pkg::vec_t  h_vec,
	output logic           out_valid,
	output rnn_pkg::data_t out
);

	localparam rnn_pkg::step_t STEP_LAST = rnn_pkg::step_t'(`RNN_STEPS - 1);
	localparam rnn_pkg::row_t  ROW_LAST  = rnn_pkg::row_t'(`RNN_DIM - 1);

	rnn_pkg::data_t u_val [`RNN_STEPS][`RNN_DIM];
	rnn_pkg::data_t w_val [`RNN_STEPS][`RNN_DIM];
	rnn_pkg::data_t h_val [`RNN_STEPS][`RNN_DIM];

	logic [`RNN_STEPS-1:0][`RNN_DIM-1:0] u_have;
	logic [`RNN_STEPS-1:0][`RNN_DIM-1:0] w_have;
	logic [`RNN_STEPS-1:0][`RNN_DIM-1:0] h_ok;

	logic           u_match;
	logic           pair_w;
	logic           pair_u;
	rnn_pkg::data_t pair_w_h;
	rnn_pkg::data_t pair_u_h;

	rnn_pkg::emit_state_t state;
	rnn_pkg::step_t       emit_step;
	rnn_pkg::row_t        emit_row;
	logic                 step_ready;
	logic                 run_end;
	rnn_pkg::data_t       y_row;

	// hidden activation, sum limited to [0, 1.0]
	function automatic rnn_pkg::data_t clamp_h(input rnn_pkg::data_t a, input rnn_pkg::data_t b);
		logic signed [`RNN_DATA_W:0] sum;
		sum = a + b;
		if (sum < 0)
			return '0;
		if (sum > `RNN_H_MAX)
			return rnn_pkg::data_t'(`RNN_H_MAX);
		return rnn_pkg::data_t'(sum);
	endfunction

	//============================================================
	// pairing of U.x and W.h rows
	//============================================================
	// w may meet its u partner in the same cycle
	assign u_match = u_proj.valid && (u_proj.step == w_proj.step) && (u_proj.row == w_proj.row);
	assign pair_w  = w_proj.valid && (u_match || u_have[w_proj.step][w_proj.row]);
	assign pair_u  = u_proj.valid && w_have[u_proj.step][u_proj.row];

	assign pair_w_h = clamp_h(u_match ? u_proj.value : u_val[w_proj.step][w_proj.row],
		w_proj.value);
	assign pair_u_h = clamp_h(u_proj.value, w_val[u_proj.step][u_proj.row]);

	always_ff @(posedge clk) begin
		if (u_proj.valid)
			u_val[u_proj.step][u_proj.row] <= u_proj.value;
		if (w_proj.valid)
			w_val[w_proj.step][w_proj.row] <= w_proj.value;
		if (pair_w)
			h_val[w_proj.step][w_proj.row] <= pair_w_h;
		if (pair_u)
			h_val[u_proj.step][u_proj.row] <= pair_u_h;
	end

	assign step_ready = &h_ok[emit_step];
	// every pair of the run is in once the last step is ready
	assign run_end = (state == rnn_pkg::emit_wait) && step_ready && (emit_step == STEP_LAST);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			u_have <= '0;
			w_have <= '0;
			h_ok   <= '0;
		end else if (run_end) begin
			u_have <= '0;
			w_have <= '0;
			h_ok   <= '0;
		end else begin
			if (u_proj.valid)
				u_have[u_proj.step][u_proj.row] <= 1'b1;
			if (w_proj.valid)
				w_have[w_proj.step][w_proj.row] <= 1'b1;
			if (pair_w)
				h_ok[w_proj.step][w_proj.row] <= 1'b1;
			if (pair_u)
				h_ok[u_proj.step][u_proj.row] <= 1'b1;
		end
	end

	//============================================================
	// publish h_t, then stream ReLU(V.h_t)
	//============================================================
	assign y_row = rnn_pkg::dot3(v_mat[emit_row], h_vec);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= rnn_pkg::emit_wait;
			emit_step <= '0;
			emit_row  <= '0;
			h_valid   <= 1'b0;
			out_valid <= 1'b0;
			out       <= '0;
		end else begin
			h_valid   <= 1'b0;
			out_valid <= 1'b0;
			out       <= '0;
			case (state)
				rnn_pkg::emit_wait: begin
					if (step_ready) begin
						// no recurrence after the final step
						h_valid   <= (emit_step != STEP_LAST);
						emit_step <= (emit_step == STEP_LAST) ? '0 : emit_step + 1'b1;
						emit_row  <= '0;
						state     <= rnn_pkg::emit_rows;
					end
				end
				rnn_pkg::emit_rows: begin
					out_valid <= 1'b1;
					out       <= y_row[`RNN_DATA_W-1] ? '0 : y_row;
					emit_row  <= emit_row + 1'b1;
					if (emit_row == ROW_LAST)
						state <= rnn_pkg::emit_wait;
				end
				default: state <= rnn_pkg::emit_wait;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == rnn_pkg::emit_wait) && step_ready) begin
			for (int r = 0; r < `RNN_DIM; r++) begin
				h_vec[r] <= h_val[emit_step][r];
			end
		end
	end

	// tags from both projections must address the 3x3 buffers
	assert property (@(posedge clk) disable iff (!rst_n)
		u_proj.valid |-> (u_proj.step <= STEP_LAST) && (u_proj.row <= ROW_LAST))
		else $error("cell_output: U.x tag out of range");

	assert property (@(posedge clk) disable iff (!rst_n)
		w_proj.valid |-> (w_proj.step <= STEP_LAST) && (w_proj.row <= ROW_LAST))
		else $error("cell_output: W.h tag out of range");

	assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !out[`RNN_DATA_W-1])
		else $error("cell_output: negative output value");

endmodule

`default_nettype wire

//--- hw/rnn_cell.sv
`default_nettype none

module rnn_cell (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_valid,
	input  rnn_pkg::data_t weight_u,
	input  rnn_pkg::data_t weight_w,
	input  rnn_pkg::data_t weight_v,
	input  rnn_pkg::data_t data_x,
	output logic           out_valid,
	output rnn_pkg::data_t out
);

	rnn_pkg::mat_t u_mat;
	rnn_pkg::mat_t w_mat;
	rnn_pkg::mat_t v_mat;
	rnn_pkg::mat_t x_mat;
	logic          start;
	logic          h_valid;
	rnn_pkg::vec_t h_vec;

	// row results from the two projections
	proj_if u_proj ();
	proj_if w_proj ();

	weight_store u_weight_store (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.weight_u (weight_u),
		.weight_w (weight_w),
		.weight_v (weight_v),
		.data_x   (data_x),
		.u_mat    (u_mat),
		.w_mat    (w_mat),
		.v_mat    (v_mat),
		.x_mat    (x_mat),
		.start    (start)
	);

	input_projection u_input_projection (
		.clk    (clk),
		.rst_n  (rst_n),
		.start  (start),
		.u_mat  (u_mat),
		.x_mat  (x_mat),
		.u_proj (u_proj.src)
	);

	recurrent_projection u_recurrent_projection (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (start),
		.h_valid (h_valid),
		.h_vec   (h_vec),
		.w_mat   (w_mat),
		.w_proj  (w_proj.src)
	);

	cell_output u_cell_output (
		.clk       (clk),
		.rst_n     (rst_n),
		.v_mat     (v_mat),
		.u_proj    (u_proj.dst),
		.w_proj    (w_proj.dst),
		.h_valid   (h_valid),
		.h_vec     (h_vec),
		.out_valid (out_valid),
		.out       (out)
	);

endmodule

`default_nettype wire

//--- sim/rnn_cell_tb.sv
`default_nettype none

`include "rnn_macros.svh"

module rnn_cell_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_RUNS   = 24;
	localparam int RUN_CYCLES = 200;
	localparam int NUM_OUT    = `RNN_STEPS * `RNN_DIM;
	localparam int DATA_MAX   = 2 ** (`RNN_DATA_W - 1) - 1;
	localparam int DATA_MIN   = -(2 ** (`RNN_DATA_W - 1));

	logic           clk;
	logic           rst_n;
	logic           in_valid;
	rnn_pkg::data_t weight_u;
	rnn_pkg::data_t weight_w;
	rnn_pkg::data_t weight_v;
	rnn_pkg::data_t data_x;
	logic           out_valid;
	rnn_pkg::data_t out;

	int exp_q [$];
	int out_seen;
	int out_total;
	int checks;
	int errors;
	int tests;

	rnn_pkg::mat_t u_m;
	rnn_pkg::mat_t w_m;
	rnn_pkg::mat_t v_m;
	rnn_pkg::mat_t x_m;

	rnn_cell uut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.weight_u  (weight_u),
		.weight_w  (weight_w),
		.weight_v  (weight_v),
		.data_x    (data_x),
		.out_valid (out_valid),
		.out       (out)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//============================================================
	// reference model
	//============================================================
	// full products, arithmetic shift, then saturate to Q8.8
	function automatic int dot_ref(input rnn_pkg::vec_t a, input rnn_pkg::vec_t b);
		longint sum;
		sum = 0;
		for (int i = 0; i < `RNN_DIM; i++) begin
			sum += longint'($signed(a[i])) * longint'($signed(b[i]));
		end
		sum = sum >>> `RNN_FRAC;
		if (sum > DATA_MAX)
			return DATA_MAX;
		if (sum < DATA_MIN)
			return DATA_MIN;
		return int'(sum);
	endfunction

	// y1..y3 in stream order, h_0 is zero
	function automatic logic [NUM_OUT-1:0][`RNN_DATA_W-1:0] reference_outputs(
		input rnn_pkg::mat_t u, input rnn_pkg::mat_t w,
		input rnn_pkg::mat_t v, input rnn_pkg::mat_t x);
		rnn_pkg::vec_t h;
		rnn_pkg::vec_t h_next;
		int pre;
		int y;
		logic [NUM_OUT-1:0][`RNN_DATA_W-1:0] res;
		h = '0;
		for (int t = 0; t < `RNN_STEPS; t++) begin
			for (int r = 0; r < `RNN_DIM; r++) begin
				pre = dot_ref(u[r], x[t]) + dot_ref(w[r], h);
				if (pre < 0)
					pre = 0;
				else if (pre > `RNN_H_MAX)
					pre = `RNN_H_MAX;
				h_next[r] = rnn_pkg::data_t'(pre);
			end
			h = h_next;
			for (int r = 0; r < `RNN_DIM; r++) begin
				y = dot_ref(v[r], h);
				res[t * `RNN_DIM + r] = (y < 0) ? '0 : rnn_pkg::data_t'(y);
			end
		end
		return res;
	endfunction

	//============================================================
	// stimulus helpers
	//============================================================
	function automatic rnn_pkg::mat_t fill_mat(input int base, input int step);
		rnn_pkg::mat_t m;
		for (int r = 0; r < `RNN_DIM; r++) begin
			for (int c = 0; c < `RNN_DIM; c++) begin
				m[r][c] = rnn_pkg::data_t'(base + step * (r * `RNN_DIM + c));
			end
		end
		return m;
	endfunction

	// span 0 gives the full 16-bit range
	function automatic rnn_pkg::data_t rand_word(input int span);
		if (span == 0)
			return rnn_pkg::data_t'($urandom);
		return rnn_pkg::data_t'(int'($urandom % 32'(2 * span)) - span);
	endfunction

	function automatic rnn_pkg::mat_t rand_mat(input int span);
		rnn_pkg::mat_t m;
		for (int r = 0; r < `RNN_DIM; r++) begin
			for (int c = 0; c < `RNN_DIM; c++) begin
				m[r][c] = rand_word(span);
			end
		end
		return m;
	endfunction

	// nine serial words, row-major, x rows are x1..x3
	task automatic load_run(input rnn_pkg::mat_t u, input rnn_pkg::mat_t w,
		input rnn_pkg::mat_t v, input rnn_pkg::mat_t x);
		logic [NUM_OUT-1:0][`RNN_DATA_W-1:0] exp_vals;
		exp_vals = reference_outputs(u, w, v, x);
		for (int i = 0; i < NUM_OUT; i++) begin
			exp_q.push_back(int'($signed(exp_vals[i])));
		end
		out_total += NUM_OUT;
		for (int k = 0; k < `RNN_LOAD_LEN; k++) begin
			@(posedge clk);
			#2;
			in_valid = 1'b1;
			weight_u = u[k / `RNN_DIM][k % `RNN_DIM];
			weight_w = w[k / `RNN_DIM][k % `RNN_DIM];
			weight_v = v[k / `RNN_DIM][k % `RNN_DIM];
			data_x   = x[k / `RNN_DIM][k % `RNN_DIM];
		end
		@(posedge clk);
		#2;
		in_valid = 1'b0;
	endtask

	task automatic wait_outputs();
		int cycles;
		cycles = 0;
		while (out_seen < out_total && cycles < RUN_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		if (out_seen < out_total) begin
			$display("Error at %0t ns: run gave only %0d of %0d outputs in %0d cycles",
				$time, out_seen, out_total, RUN_CYCLES);
			errors++;
		end
	endtask

	task automatic run_case(input rnn_pkg::mat_t u, input rnn_pkg::mat_t w,
		input rnn_pkg::mat_t v, input rnn_pkg::mat_t x);
		load_run(u, w, v, x);
		wait_outputs();
	endtask

	// settle, then confirm no stray pulses and report the test
	task automatic end_test(input string name, input int errors_before);
		repeat (12) @(posedge clk);
		if (out_seen != out_total) begin
			$display("Error at %0t ns: saw %0d out_valid pulses, expected %0d",
				$time, out_seen, out_total);
			errors++;
		end
		tests++;
		if (errors == errors_before)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
	endtask

	//============================================================
	// comparator
	//============================================================
	always @(negedge clk) begin : compare
		int expected;
		if (rst_n && out_valid) begin
			out_seen++;
			if (exp_q.size() == 0) begin
				$display("Error at %0t ns: out_valid pulsed with no output pending", $time);
				errors++;
			end else begin
				expected = exp_q.pop_front();
				checks++;
				if (out !== rnn_pkg::data_t'(expected)) begin
					$display("Mismatch at %0t ns: out expected %0d got %0d",
						$time, expected, $signed(out));
					errors++;
				end
			end
		end
	end

	initial begin : watchdog
		#((NUM_RUNS * RUN_CYCLES + 40) * CLK_PERIOD);
		$display("Error: output never completed within the time allowed for %0d runs",
			NUM_RUNS);
		$display("Testbench failed");
		$finish;
	end

	//============================================================
	// test sequence
	//============================================================
	initial begin : main
		int e0;
		void'($urandom(32'hefe5_4855));
		clk       = 1'b0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		weight_u  = '0;
		weight_w  = '0;
		weight_v  = '0;
		data_x    = '0;
		out_seen  = 0;
		out_total = 0;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// idle first, then small positive weights
		e0 = errors;
		repeat (10) @(posedge clk);
		if (out_seen != 0) begin
			$display("Error at %0t ns: out_valid rose before any load", $time);
			errors++;
		end
		run_case(fill_mat(32, 8), fill_mat(16, 8), fill_mat(24, 8), fill_mat(64, 16));
		end_test("small positive load", e0);

		// V pulls every output below zero
		e0 = errors;
		run_case(fill_mat(48, 8), fill_mat(8, 4), fill_mat(-200, -10), fill_mat(96, 16));
		end_test("relu on negative V.h", e0);

		// x3 negative so step 3 clamps at 0, earlier steps at 1.0
		e0 = errors;
		x_m = fill_mat(512, 32);
		for (int c = 0; c < `RNN_DIM; c++) begin
			x_m[2][c] = rnn_pkg::data_t'(-(512 + 32 * c));
		end
		run_case(fill_mat(1024, 64), fill_mat(-32, 4), fill_mat(64, 16), x_m);
		end_test("hidden clamp", e0);

		// operands near the word limits
		e0 = errors;
		v_m = fill_mat(32700, 7);
		for (int c = 0; c < `RNN_DIM; c++) begin
			v_m[2][c] = rnn_pkg::data_t'(DATA_MIN + c);
		end
		run_case(fill_mat(32767, -3), fill_mat(-32768, 7), v_m, fill_mat(32767, -5));
		end_test("dot product saturation", e0);

		e0 = errors;
		for (int run = 0; run < 20; run++) begin
			u_m = rand_mat((run % 3 == 0) ? 0 : ((run % 3 == 1) ? 512 : 128));
			w_m = rand_mat((run % 3 == 0) ? 0 : ((run % 3 == 1) ? 512 : 128));
			v_m = rand_mat((run % 3 == 0) ? 0 : ((run % 3 == 1) ? 512 : 128));
			x_m = rand_mat((run % 3 == 0) ? 0 : ((run % 3 == 1) ? 512 : 128));
			run_case(u_m, w_m, v_m, x_m);
		end
		end_test("twenty random runs", e0);

		if (exp_q.size() != 0) begin
			$display("Error: %0d expected outputs never arrived", exp_q.size());
			errors++;
		end
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rnn_cell.f
+incdir+hw
hw/rnn_pkg.sv
hw/proj_if.sv
hw/weight_store.sv
hw/input_projection.sv
hw/recurrent_projection.sv
hw/cell_output.sv
hw/rnn_cell.sv
sim/rnn_cell_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rnn_cell testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	-f rnn_cell.f --top-module rnn_cell_tb -o rnn_cell_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }

./obj_dir/rnn_cell_sim > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && exit 1
grep -q "Testbench passed" sim.log || { echo "simulation ended early"; exit 1; }
exit 0
